//--- all.f
mem_port_pkg.sv
ax_arbiter.sv
write_data_router.sv
resp_router.sv
mem_port_mux.sv
tb_mem_port_mux.sv

//--- ax_arbiter.sv
// round robin address arbiter
`timescale 1ns/1ps

module ax_arbiter
  import mem_port_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  // requester side
  input  ax_chan_t [NUM_SRC-1:0]  inp_data_i,
  input  logic [NUM_SRC-1:0]      inp_valid_i,
  output logic [NUM_SRC-1:0]      inp_ready_o,
  // memory side
  output ax_chan_t                oup_data_o,
  output logic                    oup_valid_o,
  input  logic                    oup_ready_i
);

  // round robin pointer, first source to look at
  logic [SEL_WIDTH-1:0] rr_ptr_q;
  // grant held under back-pressure
  logic                 hold_q;
  logic [SEL_WIDTH-1:0] grant_q;

  logic [SEL_WIDTH-1:0] rr_sel;
  logic [SEL_WIDTH-1:0] grant_sel;
  logic                 accept;

  // ----------------------------------------
  // grant selection
  // ----------------------------------------
  // first valid source at or after the pointer
  always_comb begin
    int unsigned idx;
    logic        found;
    rr_sel = rr_ptr_q;
    found  = 1'b0;
    for (int off = 0; off < NUM_SRC; off++) begin
      idx = (int'(rr_ptr_q) + off) % NUM_SRC;
      if (!found && inp_valid_i[idx]) begin
        rr_sel = SEL_WIDTH'(idx);
        found  = 1'b1;
      end
    end
  end

  // keep the stalled grant so the payload stays put
  assign grant_sel = hold_q ? grant_q : rr_sel;

  // ----------------------------------------
  // output mux and ready steering
  // ----------------------------------------
  assign oup_valid_o = |inp_valid_i;
  assign oup_data_o  = inp_data_i[grant_sel];
  assign accept      = oup_valid_o & oup_ready_i;

  // only the granted source sees ready
  always_comb begin
    for (int i = 0; i < NUM_SRC; i++) begin
      inp_ready_o[i] = oup_ready_i & (grant_sel == SEL_WIDTH'(i));
    end
  end

  // ----------------------------------------
  // pointer and hold state
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q <= '0;
      hold_q   <= 1'b0;
      grant_q  <= '0;
    end else if (accept) begin
      // next search starts one past the winner
      rr_ptr_q <= (grant_sel == SEL_WIDTH'(NUM_SRC - 1)) ? '0 : grant_sel + 1'b1;
      hold_q   <= 1'b0;
    end else if (oup_valid_o) begin
      // stalled, freeze the current winner
      hold_q  <= 1'b1;
      grant_q <= grant_sel;
    end
  end

endmodule

//--- mem_port_mux.sv
// cache memory port merger
`timescale 1ns/1ps

module mem_port_mux
  import mem_port_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  // ----------------------------------------
  // requester side, one bit or entry per source
  // ----------------------------------------
  // read address
  input  ax_chan_t [NUM_SRC-1:0] src_ar_i,
  input  logic [NUM_SRC-1:0]     src_ar_valid_i,
  output logic [NUM_SRC-1:0]     src_ar_ready_o,
  // write address
  input  ax_chan_t [NUM_SRC-1:0] src_aw_i,
  input  logic [NUM_SRC-1:0]     src_aw_valid_i,
  output logic [NUM_SRC-1:0]     src_aw_ready_o,
  // write data
  input  w_chan_t [NUM_SRC-1:0]  src_w_i,
  input  logic [NUM_SRC-1:0]     src_w_valid_i,
  output logic [NUM_SRC-1:0]     src_w_ready_o,
  // read data
  output r_chan_t [NUM_SRC-1:0]  src_r_o,
  output logic [NUM_SRC-1:0]     src_r_valid_o,
  input  logic [NUM_SRC-1:0]     src_r_ready_i,
  // write response
  output b_chan_t [NUM_SRC-1:0]  src_b_o,
  output logic [NUM_SRC-1:0]     src_b_valid_o,
  input  logic [NUM_SRC-1:0]     src_b_ready_i,

  // ----------------------------------------
  // memory side
  // ----------------------------------------
  output ax_chan_t               mem_ar_o,
  output logic                   mem_ar_valid_o,
  input  logic                   mem_ar_ready_i,
  output ax_chan_t               mem_aw_o,
  output logic                   mem_aw_valid_o,
  input  logic                   mem_aw_ready_i,
  output w_chan_t                mem_w_o,
  output logic                   mem_w_valid_o,
  input  logic                   mem_w_ready_i,
  input  r_chan_t                mem_r_i,
  input  logic                   mem_r_valid_i,
  output logic                   mem_r_ready_o,
  input  b_chan_t                mem_b_i,
  input  logic                   mem_b_valid_i,
  output logic                   mem_b_ready_o
);

  // AW ready after the write select queue check
  logic aw_ready_gated;

  // read address arbitration
  ax_arbiter u_ar_arb (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .inp_data_i  (src_ar_i),
    .inp_valid_i (src_ar_valid_i),
    .inp_ready_o (src_ar_ready_o),
    .oup_data_o  (mem_ar_o),
    .oup_valid_o (mem_ar_valid_o),
    .oup_ready_i (mem_ar_ready_i)
  );

  // write address arbitration, ready gated by the W queue
  ax_arbiter u_aw_arb (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .inp_data_i  (src_aw_i),
    .inp_valid_i (src_aw_valid_i),
    .inp_ready_o (src_aw_ready_o),
    .oup_data_o  (mem_aw_o),
    .oup_valid_o (mem_aw_valid_o),
    .oup_ready_i (aw_ready_gated)
  );

  // W beats follow AW acceptance order
  write_data_router u_w_route (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .aw_id_i       (mem_aw_o.id),
    .aw_valid_i    (mem_aw_valid_o),
    .aw_ready_i    (mem_aw_ready_i),
    .aw_ready_o    (aw_ready_gated),
    .inp_w_i       (src_w_i),
    .inp_w_valid_i (src_w_valid_i),
    .inp_w_ready_o (src_w_ready_o),
    .oup_w_o       (mem_w_o),
    .oup_w_valid_o (mem_w_valid_o),
    .oup_w_ready_i (mem_w_ready_i)
  );

  // read data back to its owner
  resp_router #(
    .payload_t (r_chan_t)
  ) u_r_route (
    .oup_id_i    (mem_r_i.id),
    .inp_data_i  (mem_r_i),
    .inp_valid_i (mem_r_valid_i),
    .inp_ready_o (mem_r_ready_o),
    .oup_data_o  (src_r_o),
    .oup_valid_o (src_r_valid_o),
    .oup_ready_i (src_r_ready_i)
  );

  // write response back to its owner
  resp_router #(
    .payload_t (b_chan_t)
  ) u_b_route (
    .oup_id_i    (mem_b_i.id),
    .inp_data_i  (mem_b_i),
    .inp_valid_i (mem_b_valid_i),
    .inp_ready_o (mem_b_ready_o),
    .oup_data_o  (src_b_o),
    .oup_valid_o (src_b_valid_o),
    .oup_ready_i (src_b_ready_i)
  );

endmodule

//--- mem_port_pkg.sv
// memory port merger definitions
package mem_port_pkg;

  // ----------------------------------------
  // channel widths
  // ----------------------------------------
  localparam int unsigned ID_WIDTH   = 4;
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 64;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;
  localparam int unsigned LEN_WIDTH  = 8;
  localparam int unsigned RESP_WIDTH = 2;

  // requesters and write select queue
  localparam int unsigned NUM_SRC       = 3;
  localparam int unsigned SEL_WIDTH     = 2;
  // one blocking burst per source plus slack
  localparam int unsigned W_QUEUE_DEPTH = 4;
  localparam int unsigned W_PTR_WIDTH   = $clog2(W_QUEUE_DEPTH);
  localparam int unsigned W_CNT_WIDTH   = $clog2(W_QUEUE_DEPTH + 1);

  // source index, also bit position in per-source vectors
  localparam logic [SEL_WIDTH-1:0] SRC_ICACHE = 2'd0;
  localparam logic [SEL_WIDTH-1:0] SRC_BYPASS = 2'd1;
  localparam logic [SEL_WIDTH-1:0] SRC_DCACHE = 2'd2;

  // fixed transaction IDs, bypass uses any ID with msb set
  localparam logic [ID_WIDTH-1:0] ID_ICACHE = 4'b0000;
  localparam logic [ID_WIDTH-1:0] ID_DCACHE = 4'b0111;

  // ----------------------------------------
  // channel payloads
  // ----------------------------------------
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } ax_chan_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
  } w_chan_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [DATA_WIDTH-1:0] data;
    logic [RESP_WIDTH-1:0] resp;
    logic                  last;
  } r_chan_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [RESP_WIDTH-1:0] resp;
  } b_chan_t;

  // owner of a transaction ID, unknown IDs go to the data cache
  function automatic logic [SEL_WIDTH-1:0] id_to_src(input logic [ID_WIDTH-1:0] id);
    logic [SEL_WIDTH-1:0] src;
    if (id[ID_WIDTH-1]) begin
      src = SRC_BYPASS;
    end else if (id == ID_ICACHE) begin
      src = SRC_ICACHE;
    end else begin
      src = SRC_DCACHE;
    end
    return src;
  endfunction

endpackage

//--- resp_router.sv
// response router by transaction ID
`timescale 1ns/1ps

module resp_router
  import mem_port_pkg::*;
#(
  parameter type payload_t = r_chan_t
) (
  // ID taken from the memory side payload
  input  logic [ID_WIDTH-1:0]     oup_id_i,
  // memory side
  input  payload_t                inp_data_i,
  input  logic                    inp_valid_i,
  output logic                    inp_ready_o,
  // requester side
  output payload_t [NUM_SRC-1:0]  oup_data_o,
  output logic [NUM_SRC-1:0]      oup_valid_o,
  input  logic [NUM_SRC-1:0]      oup_ready_i
);

  // owner of the current response
  logic [SEL_WIDTH-1:0] sel;

  // ----------------------------------------
  // ID decode
  // ----------------------------------------
  // 0000 icache, 0111 dcache, 1xxx bypass
  assign sel = id_to_src(oup_id_i);

  // ----------------------------------------
  // handshake steering
  // ----------------------------------------
  // payload goes to everyone, valid only to the owner
  always_comb begin
    for (int i = 0; i < NUM_SRC; i++) begin
      oup_data_o[i]  = inp_data_i;
      oup_valid_o[i] = inp_valid_i & (sel == SEL_WIDTH'(i));
    end
  end

  // owner back-pressure stalls the memory response
  assign inp_ready_o = oup_ready_i[sel];

endmodule

//--- tb_mem_port_mux.sv
// memory port merger testbench
`timescale 1ns/1ps

module tb_mem_port_mux
  import mem_port_pkg::*;
();

  localparam int AR_TXN     = 40;
  localparam int W_TXN      = 16;
  localparam int NUM_TXN    = AR_TXN + W_TXN;
  localparam int TIMEOUT_NS = NUM_TXN * 40 * 8;

  logic clk_i = 1'b0;
  logic reset_i;
  ax_chan_t [NUM_SRC-1:0] src_ar_i, src_aw_i;
  w_chan_t  [NUM_SRC-1:0] src_w_i;
  r_chan_t  [NUM_SRC-1:0] src_r_o;
  b_chan_t  [NUM_SRC-1:0] src_b_o;
  logic [NUM_SRC-1:0] src_ar_valid_i, src_ar_ready_o, src_aw_valid_i, src_aw_ready_o;
  logic [NUM_SRC-1:0] src_w_valid_i, src_w_ready_o, src_r_valid_o, src_r_ready_i;
  logic [NUM_SRC-1:0] src_b_valid_o, src_b_ready_i;
  ax_chan_t mem_ar_o, mem_aw_o;
  w_chan_t  mem_w_o;
  r_chan_t  mem_r_i;
  b_chan_t  mem_b_i;
  logic mem_ar_valid_o, mem_ar_ready_i, mem_aw_valid_o, mem_aw_ready_i;
  logic mem_w_valid_o, mem_w_ready_i, mem_r_valid_i, mem_r_ready_o;
  logic mem_b_valid_i, mem_b_ready_o;

  integer seed = 32'hdd32_fc41;
  int mismatches = 0;
  int other_errs = 0;
  int r_seen = 0;
  int b_seen = 0;
  int ar_left = AR_TXN;
  int w_left = W_TXN;
  // requester write state with one burst in flight per source
  logic [NUM_SRC-1:0] wr_busy = '0;
  int w_beat [NUM_SRC];
  int burst_len [NUM_SRC];
  logic [31:0] burst_tag [NUM_SRC];
  // memory side scoreboard queues
  logic [ID_WIDTH-1:0] rd_q [$];
  logic [ID_WIDTH-1:0] aw_q [$];
  logic [ID_WIDTH-1:0] b_q [$];
  w_chan_t exp_w [$];
  // arbiter reference state for AR at index 0 and AW at index 1
  logic [SEL_WIDTH-1:0] rr_ptr [2];
  logic held [2];
  logic [SEL_WIDTH-1:0] held_sel [2];
  ax_chan_t held_data [2];
  logic after_rst = 1'b1;

  mem_port_mux u_dut (.*);

  always #4 clk_i = ~clk_i;

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  // owner of an ID straight from the three ID rules
  function automatic logic [SEL_WIDTH-1:0] expected_src(input logic [ID_WIDTH-1:0] id);
    if (id[3]) return 2'd1;
    if (id == 4'b0000) return 2'd0;
    return 2'd2;
  endfunction

  // lowest offset from the pointer wins
  function automatic logic [SEL_WIDTH-1:0] rr_pick(input logic [NUM_SRC-1:0] valid,
                                                   input logic [SEL_WIDTH-1:0] ptr);
    logic [SEL_WIDTH-1:0] pick;
    int idx;
    pick = ptr;
    for (int off = NUM_SRC - 1; off >= 0; off--) begin
      idx = (int'(ptr) + off) % NUM_SRC;
      if (valid[idx]) pick = SEL_WIDTH'(idx);
    end
    return pick;
  endfunction

  // beat data tagged with source, beat number and burst tag
  function automatic w_chan_t beat_of(input int src, input int beat, input int len,
                                      input logic [31:0] tag);
    w_chan_t w;
    w.data = {8'(src), 8'(beat), 16'h0, tag};
    w.strb = '1;
    w.last = (beat == len);
    return w;
  endfunction

  // bypass picks any ID with the top bit set
  function automatic logic [ID_WIDTH-1:0] req_id(input int src);
    if (src == 1) return {1'b1, 3'($random(seed))};
    return (src == 0) ? 4'b0000 : 4'b0111;
  endfunction

  function automatic bit all_done();
    return ar_left == 0 && w_left == 0 && src_ar_valid_i == '0 && wr_busy == '0
        && rd_q.size() == 0 && b_q.size() == 0 && !mem_r_valid_i && !mem_b_valid_i;
  endfunction

  task automatic check_addr(input int ch, input string name,
                            input ax_chan_t [NUM_SRC-1:0] data,
                            input logic [NUM_SRC-1:0] valid, input logic [NUM_SRC-1:0] ready,
                            input ax_chan_t mdata, input logic mvalid, input logic mready);
    logic [SEL_WIDTH-1:0] exp_sel;
    logic [NUM_SRC-1:0] acc;
    exp_sel = held[ch] ? held_sel[ch] : rr_pick(valid, rr_ptr[ch]);
    acc = valid & ready;
    if (mvalid !== (|valid)) begin
      $display("mismatch at %0t: %s memory valid is not the OR of the sources", $time, name);
      mismatches++;
    end
    if (mvalid && mdata !== data[exp_sel]) begin
      $display("mismatch at %0t: %s payload is not that of source %0d", $time, name, exp_sel);
      mismatches++;
    end
    if (held[ch] && (!mvalid || mdata !== held_data[ch])) begin
      $display("mismatch at %0t: %s output changed under back-pressure", $time, name);
      mismatches++;
    end
    if ((mvalid && mready) !== (acc != '0) || (acc != '0 && acc != (3'b001 << exp_sel))) begin
      $display("mismatch at %0t: %s transfer at wrong source, acc %b", $time, name, acc);
      mismatches++;
    end
    if (mvalid && mready) begin
      rr_ptr[ch] = SEL_WIDTH'((int'(exp_sel) + 1) % NUM_SRC);
      held[ch] = 1'b0;
    end else if (mvalid) begin
      held[ch] = 1'b1;
      held_sel[ch] = exp_sel;
      held_data[ch] = mdata;
    end
  endtask

  task automatic check_resp(input string name, input logic [ID_WIDTH-1:0] id,
                            input logic mvalid, input logic [NUM_SRC-1:0] svalid,
                            input logic [NUM_SRC-1:0] sready, input logic mready);
    logic [SEL_WIDTH-1:0] owner;
    logic [NUM_SRC-1:0] exp_valid;
    owner = expected_src(id);
    exp_valid = mvalid ? (3'b001 << owner) : 3'b000;
    if (svalid !== exp_valid) begin
      $display("mismatch at %0t: %s id %b valids %b, expected %b", $time, name, id, svalid,
               exp_valid);
      mismatches++;
    end
    if (mvalid && mready !== sready[owner]) begin
      $display("mismatch at %0t: %s memory ready does not follow source %0d", $time, name,
               owner);
      mismatches++;
    end
  endtask

  // ----------------------------------------
  // requester and memory models
  // ----------------------------------------
  always @(posedge clk_i) begin
    int k;
    logic [LEN_WIDTH-1:0] len;
    logic [31:0] tag;
    if (!reset_i) begin
      mem_ar_ready_i <= 1'($random(seed));
      mem_aw_ready_i <= 1'($random(seed));
      mem_w_ready_i  <= 1'($random(seed));
      src_r_ready_i  <= 3'($random(seed));
      src_b_ready_i  <= 3'($random(seed));
      // memory records accepted requests
      if (mem_ar_valid_o && mem_ar_ready_i) rd_q.push_back(mem_ar_o.id);
      if (mem_aw_valid_o && mem_aw_ready_i) aw_q.push_back(mem_aw_o.id);
      if (mem_w_valid_o && mem_w_ready_i && mem_w_o.last) b_q.push_back(aw_q.pop_front());
      for (int s = 0; s < NUM_SRC; s++) begin
        if (src_ar_valid_i[s] && src_ar_ready_o[s]) begin
          src_ar_valid_i[s] <= 1'b0;
        end else if (!src_ar_valid_i[s] && ar_left > 0 && ($random(seed) & 3) == 0) begin
          src_ar_i[s] <= '{id: req_id(s), addr: $random(seed), len: '0};
          src_ar_valid_i[s] <= 1'b1;
          ar_left--;
        end
        if (src_aw_valid_i[s] && src_aw_ready_o[s]) src_aw_valid_i[s] <= 1'b0;
        if (src_w_valid_i[s] && src_w_ready_o[s]) begin
          if (src_w_i[s].last) begin
            src_w_valid_i[s] <= 1'b0;
          end else begin
            src_w_i[s] <= beat_of(s, w_beat[s] + 1, burst_len[s], burst_tag[s]);
            w_beat[s] <= w_beat[s] + 1;
          end
        end
        if (src_b_valid_o[s] && src_b_ready_i[s]) wr_busy[s] <= 1'b0;
        // icache never writes
        if (s != 0 && !wr_busy[s] && w_left > 0 && ($random(seed) & 3) == 0) begin
          len = LEN_WIDTH'($random(seed) & 3);
          tag = $random(seed);
          w_left--;
          wr_busy[s] <= 1'b1;
          src_aw_i[s] <= '{id: req_id(s), addr: $random(seed), len: len};
          src_aw_valid_i[s] <= 1'b1;
          src_w_i[s] <= beat_of(s, 0, len, tag);
          src_w_valid_i[s] <= 1'b1;
          w_beat[s] <= 0;
          burst_len[s] <= len;
          burst_tag[s] <= tag;
        end
      end
      // responses drawn from accepted requests with random gaps
      if (mem_r_valid_i && mem_r_ready_o) begin
        mem_r_valid_i <= 1'b0;
      end else if (!mem_r_valid_i && rd_q.size() > 0 && ($random(seed) & 1)) begin
        k = {$random(seed)} % rd_q.size();
        mem_r_i <= '{id: rd_q[k], data: {$random(seed), $random(seed)}, resp: 2'b00,
                     last: 1'b1};
        mem_r_valid_i <= 1'b1;
        rd_q.delete(k);
      end
      if (mem_b_valid_i && mem_b_ready_o) begin
        mem_b_valid_i <= 1'b0;
      end else if (!mem_b_valid_i && b_q.size() > 0 && ($random(seed) & 1)) begin
        k = {$random(seed)} % b_q.size();
        mem_b_i <= '{id: b_q[k], resp: 2'b00};
        mem_b_valid_i <= 1'b1;
        b_q.delete(k);
      end
    end
  end

  // ----------------------------------------
  // compare process
  // ----------------------------------------
  always @(posedge clk_i) begin
    logic [SEL_WIDTH-1:0] owner;
    w_chan_t exp_beat;
    logic [NUM_SRC-1:0] w_acc;
    after_rst <= reset_i;
    if (reset_i || after_rst) begin
      if (mem_ar_valid_o || mem_aw_valid_o || mem_w_valid_o || src_r_valid_o != '0
          || src_b_valid_o != '0) begin
        $display("mismatch at %0t: a valid is high in the reset window", $time);
        mismatches++;
      end
    end
    if (reset_i) begin
      for (int c = 0; c < 2; c++) begin
        rr_ptr[c] = '0;
        held[c] = 1'b0;
      end
    end else begin
      check_addr(0, "AR", src_ar_i, src_ar_valid_i, src_ar_ready_o, mem_ar_o,
                 mem_ar_valid_o, mem_ar_ready_i);
      check_addr(1, "AW", src_aw_i, src_aw_valid_i, src_aw_ready_o, mem_aw_o,
                 mem_aw_valid_o, mem_aw_ready_i);
      // expected W beats queued in AW order
      if (mem_aw_valid_o && mem_aw_ready_i) begin
        owner = expected_src(mem_aw_o.id);
        for (int b = 0; b <= int'(mem_aw_o.len); b++) begin
          exp_w.push_back(beat_of(owner, b, mem_aw_o.len, burst_tag[owner]));
        end
      end
      // a source side W transfer only together with the memory side one
      w_acc = src_w_valid_i & src_w_ready_o;
      if ((mem_w_valid_o && mem_w_ready_i) !== (w_acc != '0)) begin
        $display("mismatch at %0t: W source transfers %b without a memory transfer match",
                 $time, w_acc);
        mismatches++;
      end
      if (mem_w_valid_o && mem_w_ready_i) begin
        if (exp_w.size() == 0) begin
          $display("error at %0t: W beat on the memory port with no burst pending", $time);
          other_errs++;
        end else begin
          exp_beat = exp_w.pop_front();
          if (mem_w_o !== exp_beat) begin
            $display("mismatch at %0t: W beat %h, expected %h", $time, mem_w_o, exp_beat);
            mismatches++;
          end
          // top data byte names the source that owns the burst
          if (w_acc != '0 && w_acc !== (3'b001 << exp_beat.data[DATA_WIDTH-1 -: 8])) begin
            $display("mismatch at %0t: W beat taken from sources %b", $time, w_acc);
            mismatches++;
          end
        end
      end
      check_resp("R", mem_r_i.id, mem_r_valid_i, src_r_valid_o, src_r_ready_i, mem_r_ready_o);
      check_resp("B", mem_b_i.id, mem_b_valid_i, src_b_valid_o, src_b_ready_i, mem_b_ready_o);
      if (mem_r_valid_i && src_r_o[expected_src(mem_r_i.id)] !== mem_r_i) begin
        $display("mismatch at %0t: R payload not passed to its owner", $time);
        mismatches++;
      end
      if (mem_b_valid_i && src_b_o[expected_src(mem_b_i.id)] !== mem_b_i) begin
        $display("mismatch at %0t: B payload not passed to its owner", $time);
        mismatches++;
      end
      if (mem_r_valid_i && mem_r_ready_o) r_seen++;
      if (mem_b_valid_i && mem_b_ready_o) b_seen++;
    end
  end

  // watchdog allows 40 cycles per planned transaction
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    reset_i = 1'b1;
    src_ar_i = '0;
    src_ar_valid_i = '0;
    src_aw_i = '0;
    src_aw_valid_i = '0;
    src_w_i = '0;
    src_w_valid_i = '0;
    src_r_ready_i = '0;
    src_b_ready_i = '0;
    mem_ar_ready_i = 1'b0;
    mem_aw_ready_i = 1'b0;
    mem_w_ready_i = 1'b0;
    mem_r_i = '0;
    mem_r_valid_i = 1'b0;
    mem_b_i = '0;
    mem_b_valid_i = 1'b0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    while (!all_done()) @(negedge clk_i);
    if (r_seen != AR_TXN || b_seen != W_TXN || exp_w.size() != 0) begin
      $display("error: read or write responses or W beats missing at the end of the run");
      other_errs++;
    end
    $display("mismatches: %0d  other errors: %0d  reads: %0d  writes: %0d", mismatches,
             other_errs, r_seen, b_seen);
    if (mismatches == 0 && other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- write_data_router.sv
// write data source router
`timescale 1ns/1ps

module write_data_router
  import mem_port_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  // AW channel toward memory
  input  logic [ID_WIDTH-1:0]    aw_id_i,
  input  logic                   aw_valid_i,
  input  logic                   aw_ready_i,
  output logic                   aw_ready_o,
  // W beats from the requesters
  input  w_chan_t [NUM_SRC-1:0]  inp_w_i,
  input  logic [NUM_SRC-1:0]     inp_w_valid_i,
  output logic [NUM_SRC-1:0]     inp_w_ready_o,
  // W channel toward memory
  output w_chan_t                oup_w_o,
  output logic                   oup_w_valid_o,
  input  logic                   oup_w_ready_i
);

  // source select queue, in AW acceptance order
  logic [SEL_WIDTH-1:0]   queue_q [W_QUEUE_DEPTH];
  logic [W_PTR_WIDTH-1:0] wr_ptr_q;
  logic [W_PTR_WIDTH-1:0] rd_ptr_q;
  logic [W_CNT_WIDTH-1:0] count_q;

  logic                 q_full;
  logic                 q_empty;
  logic [SEL_WIDTH-1:0] aw_sel;
  logic [SEL_WIDTH-1:0] w_sel;
  logic                 push;
  logic                 pop;
  logic                 do_write;
  logic                 do_read;

  // ----------------------------------------
  // queue status and AW gating
  // ----------------------------------------
  // separate count so full and empty never alias
  assign q_full  = (count_q == W_CNT_WIDTH'(W_QUEUE_DEPTH));
  assign q_empty = (count_q == '0);

  // stall AW instead of overflowing the queue
  assign aw_ready_o = aw_ready_i & ~q_full;
  assign aw_sel     = id_to_src(aw_id_i);
  assign push       = aw_valid_i & aw_ready_o;

  // ----------------------------------------
  // W source select and mux
  // ----------------------------------------
  // empty queue falls through to an accepted AW
  // otherwise the icache, which never writes
  always_comb begin
    if (!q_empty) begin
      w_sel = queue_q[rd_ptr_q];
    end else if (push) begin
      w_sel = aw_sel;
    end else begin
      w_sel = SRC_ICACHE;
    end
  end

  assign oup_w_o       = inp_w_i[w_sel];
  assign oup_w_valid_o = inp_w_valid_i[w_sel];

  always_comb begin
    for (int i = 0; i < NUM_SRC; i++) begin
      inp_w_ready_o[i] = oup_w_ready_i & (w_sel == SEL_WIDTH'(i));
    end
  end

  // burst done on the accepted last beat
  assign pop = oup_w_valid_o & oup_w_ready_i & oup_w_o.last & (~q_empty | push);

  // fall-through burst finished in the same cycle is never stored
  assign do_write = push & ~(q_empty & pop);
  assign do_read  = pop & ~q_empty;

  // ----------------------------------------
  // queue storage and pointers
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (do_write) begin
      queue_q[wr_ptr_q] <= aw_sel;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_q <= (wr_ptr_q == W_PTR_WIDTH'(W_QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_read) begin
        rd_ptr_q <= (rd_ptr_q == W_PTR_WIDTH'(W_QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // net occupancy change
      if (do_write && !do_read) begin
        count_q <= count_q + 1'b1;
      end else if (do_read && !do_write) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule
